/* pci_tgt_macros.svh */
`ifndef PCI_TGT_MACROS_SVH
`define PCI_TGT_MACROS_SVH

// Returned in configuration register 0
`define PCI_VENDOR_ID 16'h5A5A
`define PCI_DEVICE_ID 16'h0B41

// BAR0 window is 2**PCI_BAR0_AW bytes
`define PCI_BAR0_AW 12

// Wait states before the first TRDY of a write, 0 to 7
`define PCI_INITIAL_WAIT 2

// Data phase that carries STOP with TRDY, 1 to 255
`define PCI_DISCONNECT_AFTER 8

`endif

/* pci_tgt_pkg.sv */
`default_nettype none

package pci_tgt_pkg;

	// Bus command as seen on C/BE# during the address phase
	typedef enum logic [3:0] {
		CMD_INT_ACK       = 4'h0,
		CMD_SPECIAL       = 4'h1,
		CMD_IO_READ       = 4'h2,
		CMD_IO_WRITE      = 4'h3,
		CMD_MEM_READ      = 4'h6,
		CMD_MEM_WRITE     = 4'h7,
		CMD_CFG_READ      = 4'hA,
		CMD_CFG_WRITE     = 4'hB,
		CMD_MEM_READ_MUL  = 4'hC,
		CMD_DUAL_ADDR     = 4'hD,
		CMD_MEM_READ_LN   = 4'hE,
		CMD_MEM_WRITE_INV = 4'hF
	} pci_cmd_e;

	// Type 0 configuration address layout
	typedef struct packed {
		logic [20:0] unused;
		logic [2:0]  func;       // Function number
		logic [5:0]  reg_num;    // Dword register index
		logic [1:0]  kind;       // 00 for type 0
	} pci_cfg_addr_t;

	// One address-phase word, read per command class
	typedef union packed {
		logic [31:0]   mem;      // Byte address
		pci_cfg_addr_t cfg;
	} pci_addr_u;

	// Back-end selected for a claimed transaction
	typedef enum logic {
		ACC_MEM = 1'b0,
		ACC_CFG = 1'b1
	} acc_space_e;

endpackage

`default_nettype wire

/* pci_acc_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface pci_acc_if;
	logic        valid;
	logic        ready;
	logic        write;
	logic [29:0] addr;     // Word address
	logic [31:0] wdata;
	logic [3:0]  be;       // Active high byte enables
	logic [31:0] rdata;
	logic        rvalid;   // One cycle after an accepted read

	modport fsm (
		output valid,
		output write,
		output addr,
		output wdata,
		output be,
		input  ready,
		input  rdata,
		input  rvalid
	);

	modport backend (
		input  valid,
		input  write,
		input  addr,
		input  wdata,
		input  be,
		output ready,
		output rdata,
		output rvalid
	);
endinterface

`default_nettype wire

/* pci_addr_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pci_tgt_macros.svh"

module pci_addr_decode (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [31:0]              ad_in,
	input  logic [3:0]               cbe_n,
	input  logic                     frame_n,
	input  logic                     idsel,
	input  logic [31:0]              bar0_base,
	input  logic                     mem_enable,
	input  logic                     busy,
	output logic                     claim,
	output pci_tgt_pkg::acc_space_e  acc_space,
	output logic                     is_read,
	output logic [29:0]              start_addr
);
	import pci_tgt_pkg::*;

	localparam int AW = `PCI_BAR0_AW;

	logic      frame_q;
	logic      addr_phase;
	logic      mem_hit;
	logic      cfg_hit;
	pci_addr_u addr_w;
	pci_cmd_e  cmd;

	assign addr_w = ad_in;
	assign cmd    = pci_cmd_e'(cbe_n);

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			frame_q <= 1'b1;
		else
			frame_q <= frame_n;
	end

	// Falling FRAME# starts a transaction
	assign addr_phase = frame_q && !frame_n && !busy;

	assign mem_hit = mem_enable && (addr_w.mem[31:AW] == bar0_base[31:AW]);
	assign cfg_hit = idsel && (addr_w.cfg.kind == 2'b00) && (addr_w.cfg.func == 3'd0);

	always_comb begin
		claim      = 1'b0;
		acc_space  = ACC_MEM;
		is_read    = 1'b0;
		start_addr = addr_w.mem[31:2];
		case (cmd)
			CMD_MEM_READ, CMD_MEM_READ_MUL, CMD_MEM_READ_LN: begin
				claim   = addr_phase && mem_hit;
				is_read = 1'b1;
			end
			CMD_MEM_WRITE, CMD_MEM_WRITE_INV: begin
				claim = addr_phase && mem_hit;
			end
			CMD_CFG_READ, CMD_CFG_WRITE: begin
				claim      = addr_phase && cfg_hit;
				acc_space  = ACC_CFG;
				is_read    = (cmd == CMD_CFG_READ);
				start_addr = {24'd0, addr_w.cfg.reg_num};
			end
			default: begin
				claim = 1'b0;    // Left for another target
			end
		endcase
	end
endmodule

`default_nettype wire

/* pci_tgt_fsm.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pci_tgt_macros.svh"

module pci_tgt_fsm (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [31:0]              ad_in,
	input  logic [3:0]               cbe_n,
	input  logic                     frame_n,
	input  logic                     irdy_n,
	input  logic                     claim,
	input  pci_tgt_pkg::acc_space_e  acc_space,
	input  logic                     is_read,
	input  logic [29:0]              start_addr,
	output logic [31:0]              ad_out,
	output logic                     ad_oe,
	output logic                     trdy_n,
	output logic                     stop_n,
	output logic                     devsel_n,
	output logic                     ctrl_oe,
	output logic                     par_out,
	output logic                     par_oe,
	pci_acc_if.fsm                   mem_acc,
	pci_acc_if.fsm                   cfg_acc
);
	import pci_tgt_pkg::*;

	localparam int         WW         = `PCI_BAR0_AW - 2;
	localparam logic [2:0] INIT_WAIT  = 3'(`PCI_INITIAL_WAIT);
	localparam logic [7:0] LAST_PHASE = 8'(`PCI_DISCONNECT_AFTER - 1);

	typedef enum logic [2:0] {
		S_IDLE, S_READ_TA, S_WAIT, S_ACK, S_STOP_DATA, S_STOP, S_END_TA
	} state_t;

	state_t      state, state_next;
	state_t      ack_now, ack_after;
	acc_space_e  space_q, req_space;
	logic        rd_q;
	logic        have_data;
	logic [29:0] addr_q, next_addr, req_addr;
	logic [2:0]  wait_cnt;
	logic [7:0]  phase_cnt;
	logic        xfer, go, data_avail;
	logic        rvalid_sel, ready_sel;
	logic [31:0] rdata_sel;
	logic        req_valid, req_write;

	assign xfer       = (state == S_ACK || state == S_STOP_DATA) && !irdy_n;
	assign next_addr  = {addr_q[29:WW], addr_q[WW-1:0] + 1'b1};    // Wraps in BAR window
	assign ack_now    = (phase_cnt == LAST_PHASE) ? S_STOP_DATA : S_ACK;
	assign ack_after  = (phase_cnt == LAST_PHASE - 8'd1) ? S_STOP_DATA : S_ACK;

	always_comb begin
		if (space_q == ACC_MEM) begin
			rvalid_sel = mem_acc.rvalid;
			rdata_sel  = mem_acc.rdata;
			ready_sel  = mem_acc.ready;
		end else begin
			rvalid_sel = cfg_acc.rvalid;
			rdata_sel  = cfg_acc.rdata;
			ready_sel  = cfg_acc.ready;
		end
	end

	assign data_avail = have_data || rvalid_sel;
	assign go = (wait_cnt <= 3'd1) && (rd_q ? data_avail : ready_sel);

	always_comb begin
		state_next = state;
		case (state)
			S_IDLE: if (claim) begin
				if (is_read)
					state_next = S_READ_TA;
				else if (INIT_WAIT != 3'd0)
					state_next = S_WAIT;
				else
					state_next = (LAST_PHASE == 8'd0) ? S_STOP_DATA : S_ACK;
			end
			S_READ_TA: state_next = (wait_cnt == 3'd0 && data_avail) ? ack_now : S_WAIT;
			S_WAIT: if (go) state_next = ack_now;
			S_ACK: if (!irdy_n) begin
				if (frame_n)
					state_next = S_END_TA;     // Master ended the burst
				else if (rd_q || !ready_sel)
					state_next = S_WAIT;       // Next word is being fetched
				else
					state_next = ack_after;
			end
			S_STOP_DATA: if (!irdy_n) state_next = frame_n ? S_END_TA : S_STOP;
			S_STOP: if (frame_n) state_next = S_END_TA;
			S_END_TA: state_next = S_IDLE;
			default: state_next = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state     <= S_IDLE;
			space_q   <= ACC_MEM;
			rd_q      <= 1'b0;
			addr_q    <= '0;
			wait_cnt  <= '0;
			phase_cnt <= '0;
			have_data <= 1'b0;
			ad_out    <= '0;
			par_out   <= 1'b0;
			par_oe    <= 1'b0;
		end else begin
			state   <= state_next;
			par_out <= ^{ad_out, cbe_n};
			par_oe  <= ad_oe;
			if (state == S_IDLE && claim) begin
				space_q   <= acc_space;
				rd_q      <= is_read;
				addr_q    <= start_addr;
				wait_cnt  <= INIT_WAIT;
				phase_cnt <= '0;
				have_data <= 1'b0;
			end else begin
				if (state == S_WAIT && wait_cnt != 3'd0)
					wait_cnt <= wait_cnt - 3'd1;
				if (xfer) begin
					addr_q    <= next_addr;
					phase_cnt <= phase_cnt + 8'd1;
					have_data <= 1'b0;
				end else if (rvalid_sel) begin
					have_data <= 1'b1;
				end
				if (rvalid_sel)
					ad_out <= rdata_sel;
			end
		end
	end

	// First read goes out with the claim, later ones as each phase completes
	always_comb begin
		req_space = space_q;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr  = addr_q;
		if (state == S_IDLE) begin
			req_space = acc_space;
			req_valid = claim && is_read;
			req_addr  = start_addr;
		end else if (xfer) begin
			req_valid = !rd_q || (state == S_ACK && !frame_n);
			req_write = !rd_q;
			req_addr  = rd_q ? next_addr : addr_q;
		end
	end

	assign mem_acc.valid = req_valid && (req_space == ACC_MEM);
	assign mem_acc.write = req_write;
	assign mem_acc.addr  = req_addr;
	assign mem_acc.wdata = ad_in;
	assign mem_acc.be    = ~cbe_n;
	assign cfg_acc.valid = req_valid && (req_space == ACC_CFG);
	assign cfg_acc.write = req_write;
	assign cfg_acc.addr  = req_addr;
	assign cfg_acc.wdata = ad_in;
	assign cfg_acc.be    = ~cbe_n;

	assign ctrl_oe  = (state != S_IDLE);
	assign devsel_n = !(state inside {S_READ_TA, S_WAIT, S_ACK, S_STOP_DATA, S_STOP});
	assign trdy_n   = !(state inside {S_ACK, S_STOP_DATA});
	assign stop_n   = !(state inside {S_STOP_DATA, S_STOP});
	assign ad_oe    = rd_q && (state inside {S_WAIT, S_ACK, S_STOP_DATA, S_STOP});
endmodule

`default_nettype wire

/* pci_tgt_mem.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pci_tgt_macros.svh"

module pci_tgt_mem (
	input  logic        clk,
	input  logic        rst,
	pci_acc_if.backend  acc
);
	localparam int WW    = `PCI_BAR0_AW - 2;
	localparam int DEPTH = 2 ** WW;

	logic [7:0]    lane [4][DEPTH];
	logic [WW-1:0] widx;
	logic          ready_q;

	assign widx      = acc.addr[WW-1:0];
	assign acc.ready = ready_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			ready_q <= 1'b0;
		else
			ready_q <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (acc.valid && acc.ready && acc.write) begin
			for (int i = 0; i < 4; i++) begin
				if (acc.be[i])
					lane[i][widx] <= acc.wdata[8*i +: 8];    // Masked byte lane
			end
		end
	end

	always_ff @(posedge clk) begin
		if (acc.valid && acc.ready && !acc.write)
			acc.rdata <= {lane[3][widx], lane[2][widx], lane[1][widx], lane[0][widx]};
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			acc.rvalid <= 1'b0;
		else
			acc.rvalid <= acc.valid && acc.ready && !acc.write;
	end
endmodule

`default_nettype wire

/* pci_cfg_space.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pci_tgt_macros.svh"

module pci_cfg_space (
	input  logic         clk,
	input  logic         rst,
	pci_acc_if.backend   acc,
	output logic [31:0]  bar0_base,
	output logic         mem_enable
);
	localparam logic [31:0] BAR_MASK = '1 << `PCI_BAR0_AW;    // Size bits read as 0

	logic       ready_q;
	logic       wr_en;
	logic       rd_en;
	logic [5:0] reg_num;

	assign acc.ready = ready_q;
	assign wr_en     = acc.valid && acc.ready && acc.write;
	assign rd_en     = acc.valid && acc.ready && !acc.write;
	assign reg_num   = acc.addr[5:0];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ready_q    <= 1'b0;
			bar0_base  <= '0;
			mem_enable <= 1'b0;
		end else begin
			ready_q <= 1'b1;
			if (wr_en) begin
				case (reg_num)
					6'd1: if (acc.be[0]) mem_enable <= acc.wdata[1];
					6'd4: begin
						for (int i = 0; i < 4; i++) begin
							if (acc.be[i])
								bar0_base[8*i +: 8] <= acc.wdata[8*i +: 8] & BAR_MASK[8*i +: 8];
						end
					end
					default: ;    // Unimplemented
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			case (reg_num)
				6'd0: acc.rdata <= {`PCI_DEVICE_ID, `PCI_VENDOR_ID};
				6'd1: acc.rdata <= {16'h0000, 14'd0, mem_enable, 1'b0};    // Status reads 0
				6'd4: acc.rdata <= bar0_base;
				default: acc.rdata <= '0;
			endcase
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			acc.rvalid <= 1'b0;
		else
			acc.rvalid <= rd_en;
	end
endmodule

`default_nettype wire

/* pci_tgt_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pci_tgt_top (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] ad_in,
	input  logic [3:0]  cbe_n,
	input  logic        frame_n,
	input  logic        irdy_n,
	input  logic        idsel,
	output logic [31:0] ad_out,
	output logic        ad_oe,
	output logic        trdy_n,
	output logic        stop_n,
	output logic        devsel_n,
	output logic        ctrl_oe,
	output logic        par_out,
	output logic        par_oe
);
	import pci_tgt_pkg::*;

	logic        claim;
	logic        is_read;
	acc_space_e  acc_space;
	logic [29:0] start_addr;
	logic [31:0] bar0_base;
	logic        mem_enable;

	pci_acc_if mem_acc ();
	pci_acc_if cfg_acc ();

	pci_addr_decode pci_addr_decode_inst (
		.clk        (clk),
		.rst        (rst),
		.ad_in      (ad_in),
		.cbe_n      (cbe_n),
		.frame_n    (frame_n),
		.idsel      (idsel),
		.bar0_base  (bar0_base),
		.mem_enable (mem_enable),
		.busy       (ctrl_oe),      // Target owns the bus
		.claim      (claim),
		.acc_space  (acc_space),
		.is_read    (is_read),
		.start_addr (start_addr)
	);

	pci_tgt_fsm pci_tgt_fsm_inst (
		.clk        (clk),
		.rst        (rst),
		.ad_in      (ad_in),
		.cbe_n      (cbe_n),
		.frame_n    (frame_n),
		.irdy_n     (irdy_n),
		.claim      (claim),
		.acc_space  (acc_space),
		.is_read    (is_read),
		.start_addr (start_addr),
		.ad_out     (ad_out),
		.ad_oe      (ad_oe),
		.trdy_n     (trdy_n),
		.stop_n     (stop_n),
		.devsel_n   (devsel_n),
		.ctrl_oe    (ctrl_oe),
		.par_out    (par_out),
		.par_oe     (par_oe),
		.mem_acc    (mem_acc.fsm),
		.cfg_acc    (cfg_acc.fsm)
	);

	pci_tgt_mem pci_tgt_mem_inst (
		.clk (clk),
		.rst (rst),
		.acc (mem_acc.backend)
	);

	pci_cfg_space pci_cfg_space_inst (
		.clk        (clk),
		.rst        (rst),
		.acc        (cfg_acc.backend),
		.bar0_base  (bar0_base),
		.mem_enable (mem_enable)
	);
endmodule

`default_nettype wire

/* pci_tgt_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pci_tgt_macros.svh"

module pci_tgt_tb;
	import pci_tgt_pkg::*;

	localparam int WORDS     = 2 ** (`PCI_BAR0_AW - 2);
	localparam int DISC      = `PCI_DISCONNECT_AFTER;
	localparam int N_RAND    = 12;
	localparam int MAX_LEN   = 20;
	localparam int MAX_WAIT  = 3;
	localparam int BUF_LEN   = DISC + MAX_LEN + 16;
	localparam int ALL_WORDS = WORDS + 3 * N_RAND * MAX_LEN + 3 * (DISC + 4) + 64;
	localparam int WORD_CYC  = MAX_WAIT + `PCI_INITIAL_WAIT + 12;    // Worst case, one word per burst
	localparam int WATCHDOG_NS = 2 * 4 * (ALL_WORDS * WORD_CYC + 100);
	localparam logic [31:0] BAR_MASK = 32'hFFFF_FFFF << `PCI_BAR0_AW;
	localparam logic [31:0] BAR_BASE = 32'hA5C3_7000 & BAR_MASK;

	logic        clk;
	logic        rst;
	logic [31:0] ad_in;
	logic [3:0]  cbe_n;
	logic        frame_n;
	logic        irdy_n;
	logic        idsel;
	logic [31:0] ad_out;
	logic        ad_oe;
	logic        trdy_n;
	logic        stop_n;
	logic        devsel_n;
	logic        ctrl_oe;
	logic        par_out;
	logic        par_oe;

	logic        want_claim;     // Address phase on the bus should be claimed
	logic        expect_idle;    // Unclaimed transaction in progress
	logic        saw_stop;
	logic        idle_bus;
	int          max_wait;
	string       test_name;
	logic [31:0] data_buf [BUF_LEN];
	logic [3:0]  be_buf [BUF_LEN];
	logic [31:0] rd_buf [BUF_LEN];
	logic [7:0]  ref_mem [WORDS * 4];    // Byte lanes of the BAR window

	pci_tgt_top pci_tgt_top_inst (
		.clk      (clk),
		.rst      (rst),
		.ad_in    (ad_in),
		.cbe_n    (cbe_n),
		.frame_n  (frame_n),
		.irdy_n   (irdy_n),
		.idsel    (idsel),
		.ad_out   (ad_out),
		.ad_oe    (ad_oe),
		.trdy_n   (trdy_n),
		.stop_n   (stop_n),
		.devsel_n (devsel_n),
		.ctrl_oe  (ctrl_oe),
		.par_out  (par_out),
		.par_oe   (par_oe)
	);

	assign idle_bus = !ctrl_oe && !ad_oe && !par_oe && trdy_n && stop_n && devsel_n;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		fail_run("Watchdog expired, the DUT stopped responding");
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
			else fail_run($sformatf("MISMATCH %s expected %h actual %h", test_name, exp, act));
	endtask

	devsel_fast: assert property (@(posedge clk) disable iff (rst)
		($fell(frame_n) && want_claim) |=> !devsel_n)
		else fail_run("devsel_n did not fall one cycle after a claimed address phase");

	hold_on_wait: assert property (@(posedge clk) disable iff (rst)
		(!trdy_n && irdy_n) |=> ($stable(trdy_n) && $stable(stop_n) && $stable(ad_out)))
		else fail_run("trdy_n, stop_n or ad_out changed while irdy_n was high");

	par_value: assert property (@(posedge clk) disable iff (rst)
		par_oe |-> (par_out == ^{$past(ad_out), $past(cbe_n)}))
		else fail_run("par_out is not the even parity of the previous ad_out and cbe_n");

	par_enable: assert property (@(posedge clk) disable iff (rst) par_oe == $past(ad_oe))
		else fail_run("par_oe does not follow ad_oe by one cycle");

	reset_idle: assert property (@(posedge clk) $fell(rst) |->
		(idle_bus && !pci_tgt_top_inst.mem_acc.valid && !pci_tgt_top_inst.cfg_acc.valid))
		else fail_run("Outputs or back-end requests active right after reset");

	unclaimed_idle: assert property (@(posedge clk) disable iff (rst) expect_idle |-> idle_bus)
		else fail_run("DUT drove the bus during an unclaimed transaction");

	release_after_ta: assert property (@(posedge clk) disable iff (rst)
		(ctrl_oe && devsel_n) |=> idle_bus)
		else fail_run("Output enables still high after the end turnaround");

	function automatic logic [31:0] ref_word(input int idx);
		return {ref_mem[idx*4+3], ref_mem[idx*4+2], ref_mem[idx*4+1], ref_mem[idx*4]};
	endfunction

	function automatic logic [31:0] addr_of(input int word);
		return BAR_BASE + 32'((word % WORDS) * 4);
	endfunction

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return addr ^ {addr[7:0], addr[31:8]} ^ 32'h5A3C_C3A5;
	endfunction

	// One master transaction; done counts the data phases that transferred
	task automatic run_burst(input logic [3:0] cmd, input logic [31:0] addr, input logic sel,
			input int first, input int n, input logic claim_exp, output int done);
		int   waits;
		int   cyc;
		logic wr;
		logic ended;
		wr       = cmd[0];    // Write commands are odd
		done     = 0;
		cyc      = 0;
		ended    = 1'b0;
		saw_stop = 1'b0;
		waits    = $urandom_range(0, max_wait);
		@(negedge clk);
		frame_n     = 1'b0;
		irdy_n      = 1'b1;
		ad_in       = addr;
		cbe_n       = cmd;
		idsel       = sel;
		want_claim  = claim_exp;
		expect_idle = !claim_exp;
		while (!ended) begin
			@(negedge clk);
			cyc++;
			idsel      = 1'b0;
			want_claim = 1'b0;
			if (devsel_n && cyc > 5) begin
				frame_n = 1'b1;    // Master abort
				irdy_n  = 1'b0;
				ended   = 1'b1;
			end else begin
				if (waits != 0 && !saw_stop) begin
					irdy_n = 1'b1;
					waits--;
				end else begin
					irdy_n = 1'b0;
				end
				ad_in = wr ? data_buf[first + done] : 32'h0;
				cbe_n = ~be_buf[first + done];
				if (!irdy_n && (done == n - 1 || saw_stop))
					frame_n = 1'b1;
				if (!irdy_n && frame_n && (!trdy_n || !stop_n))
					ended = 1'b1;
				if (!irdy_n && !trdy_n) begin
					if (!wr)
						rd_buf[first + done] = ad_out;
					done++;
					waits = $urandom_range(0, max_wait);
				end
				if (!stop_n)
					saw_stop = 1'b1;
			end
		end
		@(negedge clk);
		frame_n = 1'b1;
		irdy_n  = 1'b1;
		ad_in   = '0;
		cbe_n   = '0;
		while (ctrl_oe)
			@(negedge clk);
		expect_idle = 1'b0;
	endtask

	task automatic model_write(input int word, input int n);
		int k;
		int b;
		int idx;
		for (k = 0; k < n; k++) begin
			idx = (word + k) % WORDS;
			for (b = 0; b < 4; b++) begin
				if (be_buf[k][b])
					ref_mem[idx*4 + b] = data_buf[k][8*b +: 8];
			end
		end
	endtask

	// Resumes at the next word after each disconnect
	task automatic mem_access(input logic wr, input int word, input int n);
		int done;
		int got;
		done = 0;
		while (done < n) begin
			run_burst(wr ? CMD_MEM_WRITE : CMD_MEM_READ, addr_of(word + done), 1'b0,
				done, n - done, 1'b1, got);
			if (got == 0)
				fail_run("Memory burst was claimed but transferred no data");
			done += got;
		end
		if (wr)
			model_write(word, n);
	endtask

	task automatic check_read(input int word, input int n);
		int k;
		for (k = 0; k < n; k++)
			check_word(ref_word((word + k) % WORDS), rd_buf[k]);
	endtask

	task automatic load_random(input int n);
		int k;
		for (k = 0; k < n; k++) begin
			data_buf[k] = $urandom();
			be_buf[k]   = 4'($urandom_range(0, 15));
		end
	endtask

	task automatic cfg_read(input int reg_num, output logic [31:0] val);
		int got;
		be_buf[0] = 4'hF;
		run_burst(CMD_CFG_READ, 32'(reg_num * 4), 1'b1, 0, 1, 1'b1, got);
		check_word(32'd1, got);
		val = rd_buf[0];
	endtask

	task automatic cfg_write(input int reg_num, input logic [31:0] val);
		int got;
		data_buf[0] = val;
		be_buf[0]   = 4'hF;
		run_burst(CMD_CFG_WRITE, 32'(reg_num * 4), 1'b1, 0, 1, 1'b1, got);
		check_word(32'd1, got);
	endtask

	task automatic expect_miss(input logic [3:0] cmd, input logic [31:0] addr);
		int got;
		data_buf[0] = ~addr;
		be_buf[0]   = 4'hF;
		run_burst(cmd, addr, 1'b0, 0, 1, 1'b0, got);
		check_word(32'd0, got);
	endtask

	initial begin : main_seq
		int          got;
		int          word;
		int          len;
		int          k;
		int          t;
		logic [31:0] val;
		void'($urandom(42));
		rst         = 1'b1;
		ad_in       = '0;
		cbe_n       = '0;
		frame_n     = 1'b1;
		irdy_n      = 1'b1;
		idsel       = 1'b0;
		want_claim  = 1'b0;
		expect_idle = 1'b0;
		saw_stop    = 1'b0;
		max_wait    = 0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		test_name = "config_id";
		cfg_read(0, val);
		check_word({`PCI_DEVICE_ID, `PCI_VENDOR_ID}, val);
		run_burst(CMD_CFG_READ, 32'h0, 1'b0, 0, 1, 1'b0, got);    // No IDSEL
		check_word(32'd0, got);

		test_name = "bar_sizing";
		cfg_write(4, 32'hFFFF_FFFF);
		cfg_read(4, val);
		check_word(BAR_MASK, val);
		cfg_write(4, BAR_BASE);
		cfg_write(1, 32'h0000_0002);
		cfg_read(4, val);
		check_word(BAR_BASE, val);
		cfg_read(1, val);
		check_word(32'h0000_0002, val);

		test_name = "fill";
		for (word = 0; word < WORDS; word += 16) begin
			for (k = 0; k < 16; k++) begin
				data_buf[k] = fill_word(addr_of(word + k));
				be_buf[k]   = 4'hF;
			end
			mem_access(1'b1, word, 16);
		end

		test_name = "bursts";
		max_wait  = MAX_WAIT;
		for (t = 0; t < N_RAND; t++) begin
			len  = $urandom_range(1, MAX_LEN);
			word = (t % 3 == 0) ? WORDS - $urandom_range(1, 6) : $urandom_range(0, WORDS - 1);
			load_random(len);
			mem_access(1'b1, word, len);
			load_random(len);
			mem_access(1'b0, word, len);
			check_read(word, len);
		end

		test_name = "disconnect";
		len  = DISC + 4;
		word = $urandom_range(0, WORDS - 1);
		load_random(len);
		run_burst(CMD_MEM_WRITE, addr_of(word), 1'b0, 0, len, 1'b1, got);
		check_word(DISC, got);
		check_word(32'd1, saw_stop);
		run_burst(CMD_MEM_WRITE, addr_of(word + got), 1'b0, got, len - got, 1'b1, got);
		check_word(len - DISC, got);
		model_write(word, len);
		mem_access(1'b0, word, len);
		check_read(word, len);

		test_name = "decode_miss";
		word = $urandom_range(0, WORDS - 1);
		expect_miss(CMD_MEM_WRITE, addr_of(word) ^ 32'h8000_0000);
		cfg_write(1, 32'h0);
		expect_miss(CMD_MEM_WRITE, addr_of(word));
		cfg_write(1, 32'h0000_0002);
		expect_miss(CMD_IO_WRITE, addr_of(word));
		be_buf[0] = 4'hF;
		mem_access(1'b0, word, 1);
		check_read(word, 1);

		test_name = "parity";
		word = $urandom_range(0, WORDS - 1);
		load_random(MAX_LEN);
		mem_access(1'b0, word, MAX_LEN);
		check_read(word, MAX_LEN);
		@(negedge clk);
		check_word(32'd0, {ctrl_oe, ad_oe, par_oe});

		$display("SIMULATION PASSED");
		$finish;
	end
endmodule

`default_nettype wire

/* list.f */
+incdir+.
pci_tgt_pkg.sv
pci_acc_if.sv
pci_addr_decode.sv
pci_tgt_fsm.sv
pci_tgt_mem.sv
pci_cfg_space.sv
pci_tgt_top.sv
pci_tgt_tb.sv
